// File: fetch_buffer_tests.txt
# T n | P/X pc npc ir_lo ir_hi pre plv excp [takes] | S pc npc ir pre plv excp | K/H/I n | F
# E valid0 valid1 ir0 ir1 pc0 pc1 excp_arg1 stall_fb | N npc pre plv excp_arg0 (fields in hex)
T 1
E 0 0 0 0 0 0 0 0
T 2
P 00001000 00001008 0000a001 0000a002 0123456789abcdef 1 0055
E 1 1 0000a001 0000a002 00001000 00001004 0000 0
N 00001008 0123456789abcdef 1 0055
K 2
E 0 0 0 0 0 0 0 0
T 3
S 00002000 00002004 0000b001 0000000000000011 2 0011
P 00002004 0000200c 0000b002 0000b003 0000000000000022 2 0022
S 0000200c 00002010 0000b004 0000000000000033 2 0033
E 1 1 0000b001 0000b002 00002000 00002004 0022 0
K 1
E 1 1 0000b002 0000b003 00002004 00002008 0000 0
P 00002010 00002018 0000b005 0000b006 0000000000000044 2 0044
K 2
E 1 1 0000b004 0000b005 0000200c 00002010 0044 0
K 1
E 1 1 0000b005 0000b006 00002010 00002014 0000 0
K 2
E 0 0 0 0 0 0 0 0
S 00002018 0000201c 0000b007 0000000000000055 2 0055
E 1 0 0000b007 0 00002018 0 0 0
K 1
E 0 0 0 0 0 0 0 0
T 4
P 00003000 00003008 0000c001 0000c002 0000000000000004 0 0066
P 00003008 00003010 0000c003 0000c004 0000000000000004 0 0066
P 00003010 00003018 0000c005 0000c006 0000000000000004 0 0066
P 00003018 00003020 0000c007 0000c008 0000000000000004 0 0066
P 00003020 00003028 0000c009 0000c00a 0000000000000004 0 0066
P 00003028 00003030 0000c00b 0000c00c 0000000000000004 0 0066
P 00003030 00003038 0000c00d 0000c00e 0000000000000004 0 0066
P 00003038 00003040 0000c00f 0000c010 0000000000000004 0 0066
E 1 1 0000c001 0000c002 00003000 00003004 0000 1
K 2
E 1 1 0000c003 0000c004 00003008 0000300c 0000 0
P 00003040 00003048 0000c011 0000c012 0000000000000004 0 0066
E 1 1 0000c003 0000c004 00003008 0000300c 0000 1
T 5
F
E 0 0 0 0 0 0 0 0
P 00004000 00004008 0000d001 0000d002 00000000000000ff 3 0077
H 4
E 1 1 0000d001 0000d002 00004000 00004004 0000 0
N 00004008 00000000000000ff 3 0077
K 1
E 1 0 0000d002 0 00004004 0 0 0
S 00004008 0000400c 0000d003 00000000000000ff 3 0088
E 1 1 0000d002 0000d003 00004004 00004008 0088 0
F
E 0 0 0 0 0 0 0 0
S 00004100 00004104 0000d004 00000000000000aa 1 0099
S 00004104 00004108 0000d005 00000000000000aa 1 00aa
E 1 1 0000d004 0000d005 00004100 00004104 00aa 0
T 6
X 00005000 00005008 0000d006 0000d007 0000000000000066 0 00bb 1
E 1 1 0000d005 0000d006 00004104 00005000 00bb 0
X 00005008 00005010 0000d008 0000d009 0000000000000066 0 00cc 2
E 1 1 0000d007 0000d008 00005004 00005008 00cc 0
K 2
E 1 0 0000d009 0 0000500c 0 0 0
K 1
E 0 0 0 0 0 0 0 0

// File: files.f
fb_pkg.sv
fetch_packet_splitter.sv
fetch_bank.sv
issue_merger.sv
fetch_buffer.sv
fetch_buffer_asserts.sv
tb_clock_gen.sv
tb_fetch_buffer.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_fetch_buffer

output=$(./obj_dir/Vtb_fetch_buffer)
echo "$output"

if grep -q "Test completed successfully" <<< "$output"; then
    exit 0
fi
exit 1

// File: tb_fetch_buffer.sv
`timescale 1ns/1ps

module tb_fetch_buffer import fb_pkg::*;
();

    logic               clk;
    logic               rstn;
    logic               flush;
    logic               stall;
    logic               icache_valid;
    logic               flag;
    logic [XLEN-1:0]    pc;
    logic [XLEN-1:0]    npc;
    logic [FETCH_W-1:0] irin;
    logic [PRE_W-1:0]   pre;
    logic [PLV_W-1:0]   plv;
    logic [EXCP_W-1:0]  excp_arg;
    logic               if0;
    logic               if1;
    logic [XLEN-1:0]    ir0;
    logic [XLEN-1:0]    ir1;
    logic [XLEN-1:0]    pc0;
    logic [XLEN-1:0]    pc1;
    logic [XLEN-1:0]    npc0;
    logic [XLEN-1:0]    npc1;
    logic [PRE_W-1:0]   pre0;
    logic [PRE_W-1:0]   pre1;
    logic [PLV_W-1:0]   plv0;
    logic [PLV_W-1:0]   plv1;
    logic [EXCP_W-1:0]  excp_arg0;
    logic [EXCP_W-1:0]  excp_arg1;
    logic               valid0;
    logic               valid1;
    logic               stall_fetch_buffer;

    integer seed;
    integer fd;
    int     errors;
    int     checks;
    int     test_num;
    int     test_checks;
    int     test_errors;
    int     tests_run;
    bit     timed_out;

    tb_clock_gen i_clock_gen
    (
        .clk  (clk),
        .rstn (rstn)
    );

    fetch_buffer i_fetch_buffer
    (
        .clk                (clk),
        .rstn               (rstn),
        .flush              (flush),
        .stall              (stall),
        .icache_valid       (icache_valid),
        .flag               (flag),
        .pc                 (pc),
        .npc                (npc),
        .irin               (irin),
        .pre                (pre),
        .plv                (plv),
        .excp_arg           (excp_arg),
        .if0                (if0),
        .if1                (if1),
        .ir0                (ir0),
        .ir1                (ir1),
        .pc0                (pc0),
        .pc1                (pc1),
        .npc0               (npc0),
        .npc1               (npc1),
        .pre0               (pre0),
        .pre1               (pre1),
        .plv0               (plv0),
        .plv1               (plv1),
        .excp_arg0          (excp_arg0),
        .excp_arg1          (excp_arg1),
        .valid0             (valid0),
        .valid1             (valid1),
        .stall_fetch_buffer (stall_fetch_buffer)
    );

    bind fetch_buffer fetch_buffer_asserts i_asserts
    (
        .clk                (clk),
        .rstn               (rstn),
        .flush              (flush),
        .icache_valid       (icache_valid),
        .stall_fetch_buffer (stall_fetch_buffer),
        .if0                (if0),
        .if1                (if1),
        .valid0             (valid0),
        .valid1             (valid1)
    );

    // ------------------------------------------------------------
    // Drivers
    // ------------------------------------------------------------

    task automatic set_idle_inputs();
        icache_valid <= 1'b0;
        flag         <= 1'b0;
        if0          <= 1'b0;
        if1          <= 1'b0;
        stall        <= 1'b0;
        flush        <= 1'b0;
    endtask

    task automatic wait_buffer_ready();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (stall_fetch_buffer && cnt < 32)
        begin
            @(negedge clk);
            cnt++;
        end
        if (stall_fetch_buffer)
        begin
            $display("Timed out waiting for stall_fetch_buffer to drop at %0t", $time);
            timed_out = 1'b1;
        end
    endtask

    task automatic deliver(
        input logic              pair,
        input logic [XLEN-1:0]   d_pc,
        input logic [XLEN-1:0]   d_npc,
        input logic [XLEN-1:0]   d_ir_lo,
        input logic [XLEN-1:0]   d_ir_hi,
        input logic [PRE_W-1:0]  d_pre,
        input logic [PLV_W-1:0]  d_plv,
        input logic [EXCP_W-1:0] d_excp,
        input int                takes
    );
        wait_buffer_ready();
        if (!timed_out)
        begin
            @(posedge clk);
            icache_valid <= 1'b1;
            flag         <= pair;
            pc           <= d_pc;
            npc          <= d_npc;
            irin         <= {d_ir_hi, d_ir_lo};
            pre          <= d_pre;
            plv          <= d_plv;
            excp_arg     <= d_excp;
            if0          <= (takes > 0);
            if1          <= (takes > 1);
            @(posedge clk);
            set_idle_inputs();
        end
    endtask

    task automatic take(input int takes);
        @(posedge clk);
        if0 <= (takes > 0);
        if1 <= (takes > 1);
        @(posedge clk);
        set_idle_inputs();
    endtask

    // Offers a delivery and a double take that must both be ignored
    task automatic hold_stall(input int cycles);
        @(posedge clk);
        stall        <= 1'b1;
        icache_valid <= 1'b1;
        flag         <= 1'b1;
        pc           <= 32'h0000dead;
        npc          <= 32'h0000beef;
        irin         <= {32'h0000dead, 32'h0000beef};
        excp_arg     <= 16'hdead;
        if0          <= 1'b1;
        if1          <= 1'b1;
        repeat (cycles) @(posedge clk);
        set_idle_inputs();
    endtask

    task automatic flush_buffer();
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        set_idle_inputs();
    endtask

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    task automatic check_slots(
        input logic              ev0,
        input logic              ev1,
        input logic [XLEN-1:0]   eir0,
        input logic [XLEN-1:0]   eir1,
        input logic [XLEN-1:0]   epc0,
        input logic [XLEN-1:0]   epc1,
        input logic [EXCP_W-1:0] eexcp1,
        input logic              esfb
    );
        @(negedge clk);
        checks++;
        test_checks++;
        assert (valid0 === ev0 && valid1 === ev1 && stall_fetch_buffer === esfb)
        else
        begin
            $display("CHECK FAILED at %0t: valid0 %b valid1 %b stall_fetch_buffer %b, want %b %b %b",
                     $time, valid0, valid1, stall_fetch_buffer, ev0, ev1, esfb);
            count_error();
        end
        if (ev0)
            assert (ir0 === eir0 && pc0 === epc0)
            else
            begin
                $display("CHECK FAILED at %0t: slot 0 ir %h pc %h, want %h %h",
                         $time, ir0, pc0, eir0, epc0);
                count_error();
            end
        if (ev1)
            assert (ir1 === eir1 && pc1 === epc1 && excp_arg1 === eexcp1)
            else
            begin
                $display("CHECK FAILED at %0t: slot 1 ir %h pc %h excp %h, want %h %h %h",
                         $time, ir1, pc1, excp_arg1, eir1, epc1, eexcp1);
                count_error();
            end
    endtask

    task automatic check_sideband(
        input logic [XLEN-1:0]   enpc,
        input logic [PRE_W-1:0]  epre,
        input logic [PLV_W-1:0]  eplv,
        input logic [EXCP_W-1:0] eexcp0
    );
        @(negedge clk);
        checks++;
        test_checks++;
        assert (npc0 === enpc && npc1 === enpc && pre0 === epre && pre1 === epre
                && plv0 === eplv && plv1 === eplv && excp_arg0 === eexcp0)
        else
        begin
            $display("CHECK FAILED at %0t: npc %h/%h pre %h/%h plv %h/%h excp0 %h",
                     $time, npc0, npc1, pre0, pre1, plv0, plv1, excp_arg0);
            count_error();
        end
    endtask

    function automatic void report_test();
        tests_run++;
        $display("Test %0d done: %0d checks, %0d errors", test_num, test_checks, test_errors);
    endfunction

    // ------------------------------------------------------------
    // Command interpreter
    // ------------------------------------------------------------

    task automatic run_command(input string text);
        logic [7:0]        cmd;
        string             args;
        logic [XLEN-1:0]   a_pc;
        logic [XLEN-1:0]   a_pc1;
        logic [XLEN-1:0]   a_ir0;
        logic [XLEN-1:0]   a_ir1;
        logic [PRE_W-1:0]  a_pre;
        logic [PLV_W-1:0]  a_plv;
        logic [EXCP_W-1:0] a_excp;
        logic              a_v0;
        logic              a_v1;
        logic              a_sfb;
        int                num;
        int                fields;
        int                want;
        int                idle;
        cmd    = text.getc(0);
        args   = text.substr(1, text.len() - 1);
        fields = 0;
        case (cmd)
            "T", "K", "H", "I":
            begin
                want   = 1;
                fields = $sscanf(args, "%d", num);
            end
            "P":
            begin
                want   = 7;
                fields = $sscanf(args, "%h %h %h %h %h %h %h",
                                 a_pc, a_pc1, a_ir0, a_ir1, a_pre, a_plv, a_excp);
            end
            "X":
            begin
                want   = 8;
                fields = $sscanf(args, "%h %h %h %h %h %h %h %d",
                                 a_pc, a_pc1, a_ir0, a_ir1, a_pre, a_plv, a_excp, num);
            end
            "S":
            begin
                want   = 6;
                fields = $sscanf(args, "%h %h %h %h %h %h",
                                 a_pc, a_pc1, a_ir0, a_pre, a_plv, a_excp);
            end
            "E":
            begin
                want   = 8;
                fields = $sscanf(args, "%h %h %h %h %h %h %h %h",
                                 a_v0, a_v1, a_ir0, a_ir1, a_pc, a_pc1, a_excp, a_sfb);
            end
            "N":
            begin
                want   = 4;
                fields = $sscanf(args, "%h %h %h %h", a_pc1, a_pre, a_plv, a_excp);
            end
            "F":
                want = 0;
            default:
                want = -1;
        endcase

        if (fields != want)
        begin
            $display("Bad line in the tests file: %s", text);
            count_error();
        end
        else
        begin
            case (cmd)
                "T":
                begin
                    if (test_num != 0)
                        report_test();
                    test_num    = num;
                    test_checks = 0;
                    test_errors = 0;
                end
                "P": deliver(1'b1, a_pc, a_pc1, a_ir0, a_ir1, a_pre, a_plv, a_excp, 0);
                "X": deliver(1'b1, a_pc, a_pc1, a_ir0, a_ir1, a_pre, a_plv, a_excp, num);
                "S": deliver(1'b0, a_pc, a_pc1, a_ir0, '0, a_pre, a_plv, a_excp, 0);
                "K": take(num);
                "H": hold_stall(num);
                "I": repeat (num) @(posedge clk);
                "F": flush_buffer();
                "E": check_slots(a_v0, a_v1, a_ir0, a_ir1, a_pc, a_pc1, a_excp, a_sfb);
                "N": check_sideband(a_pc1, a_pre, a_plv, a_excp);
                default: ;
            endcase
            // Random gap after commands that move the DUT
            if (cmd != "T" && cmd != "E" && cmd != "N")
            begin
                idle = $random(seed) & 3;
                repeat (idle) @(posedge clk);
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial
    begin
        int    cnt;
        string text;
        seed        = 32'h22b856fc;
        errors      = 0;
        checks      = 0;
        test_num    = 0;
        test_checks = 0;
        test_errors = 0;
        tests_run   = 0;
        timed_out   = 1'b0;
        pc          <= '0;
        npc         <= '0;
        irin        <= '0;
        pre         <= '0;
        plv         <= '0;
        excp_arg    <= '0;
        set_idle_inputs();

        cnt = 0;
        while (rstn !== 1'b1 && cnt < 40)
        begin
            @(negedge clk);
            cnt++;
        end
        if (rstn !== 1'b1)
        begin
            $display("Timed out waiting for reset release");
            timed_out = 1'b1;
        end

        fd = $fopen("fetch_buffer_tests.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open fetch_buffer_tests.txt");
            errors++;
        end
        else
        begin
            while (!timed_out && !$feof(fd))
            begin
                if ($fgets(text, fd) > 0 && text.len() > 1 && text.getc(0) != "#")
                    run_command(text);
            end
            $fclose(fd);
        end

        if (test_num != 0)
            report_test();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0 && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic rstn
);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;                // 10 ns period
    end

    initial
    begin
        rstn <= 1'b0;
        repeat (8) @(posedge clk);
        rstn <= 1'b1;
    end

endmodule

// File: fetch_buffer_asserts.sv
`timescale 1ns/1ps

module fetch_buffer_asserts
(
    input logic clk,
    input logic rstn,
    input logic flush,
    input logic icache_valid,
    input logic stall_fetch_buffer,
    input logic if0,
    input logic if1,
    input logic valid0,
    input logic valid1
);

    // Cache side holds off while a bank is full
    no_delivery_when_full: assert property (@(posedge clk) disable iff (!rstn)
        stall_fetch_buffer |-> !icache_valid)
        else $error("icache_valid high while stall_fetch_buffer is high");

    slot1_needs_slot0: assert property (@(posedge clk) disable iff (!rstn)
        valid1 |-> valid0)
        else $error("valid1 high without valid0");

    take1_needs_take0: assert property (@(posedge clk) disable iff (!rstn)
        if1 |-> if0)
        else $error("if1 high without if0");

    // Everything empties at the flush edge
    empty_after_flush: assert property (@(posedge clk) disable iff (!rstn)
        flush |=> !valid0)
        else $error("valid0 high in the cycle after a flush");

endmodule

// File: fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer import fb_pkg::*;
(
    input  logic                clk,
    input  logic                rstn,
    input  logic                flush,
    input  logic                stall,
    input  logic                icache_valid,
    input  logic                flag,
    input  logic [XLEN-1:0]     pc,
    input  logic [XLEN-1:0]     npc,
    input  logic [FETCH_W-1:0]  irin,
    input  logic [PRE_W-1:0]    pre,
    input  logic [PLV_W-1:0]    plv,
    input  logic [EXCP_W-1:0]   excp_arg,
    input  logic                if0,
    input  logic                if1,
    output logic [XLEN-1:0]     ir0,
    output logic [XLEN-1:0]     ir1,
    output logic [XLEN-1:0]     pc0,
    output logic [XLEN-1:0]     pc1,
    output logic [XLEN-1:0]     npc0,
    output logic [XLEN-1:0]     npc1,
    output logic [PRE_W-1:0]    pre0,
    output logic [PRE_W-1:0]    pre1,
    output logic [PLV_W-1:0]    plv0,
    output logic [PLV_W-1:0]    plv1,
    output logic [EXCP_W-1:0]   excp_arg0,
    output logic [EXCP_W-1:0]   excp_arg1,
    output logic                valid0,
    output logic                valid1,
    output logic                stall_fetch_buffer
);

    // Splitter to banks
    logic [NUM_BANKS-1:0]                  bank_push;
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_ir;
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_pc;
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_npc;
    logic [NUM_BANKS-1:0][PRE_W-1:0]       bank_pre;
    logic [NUM_BANKS-1:0][PLV_W-1:0]       bank_plv;
    logic [NUM_BANKS-1:0][EXCP_W-1:0]      bank_excp_arg;

    // Banks to merger and splitter
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_head_ir;
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_head_pc;
    logic [NUM_BANKS-1:0][XLEN-1:0]        bank_head_npc;
    logic [NUM_BANKS-1:0][PRE_W-1:0]       bank_head_pre;
    logic [NUM_BANKS-1:0][PLV_W-1:0]       bank_head_plv;
    logic [NUM_BANKS-1:0][EXCP_W-1:0]      bank_head_excp_arg;
    logic [NUM_BANKS-1:0]                  bank_empty;
    logic [NUM_BANKS-1:0][BANK_CNT_W-1:0]  bank_count;
    logic [NUM_BANKS-1:0]                  bank_pop;

    fetch_packet_splitter i_splitter
    (
        .clk                (clk),
        .rstn               (rstn),
        .stall              (stall),
        .flush              (flush),
        .icache_valid       (icache_valid),
        .flag               (flag),
        .pc                 (pc),
        .npc                (npc),
        .irin               (irin),
        .pre                (pre),
        .plv                (plv),
        .excp_arg           (excp_arg),
        .bank_count         (bank_count),
        .bank_push          (bank_push),
        .bank_ir            (bank_ir),
        .bank_pc            (bank_pc),
        .bank_npc           (bank_npc),
        .bank_pre           (bank_pre),
        .bank_plv           (bank_plv),
        .bank_excp_arg      (bank_excp_arg),
        .stall_fetch_buffer (stall_fetch_buffer)
    );

    // ------------------------------------------------------------
    // Instruction banks
    // ------------------------------------------------------------

    for (genvar b = 0; b < NUM_BANKS; b++)
    begin : g_bank
        fetch_bank i_bank
        (
            .clk           (clk),
            .rstn          (rstn),
            .flush         (flush),
            .stall         (stall),
            .push          (bank_push[b]),
            .pop           (bank_pop[b]),
            .ir            (bank_ir[b]),
            .pc            (bank_pc[b]),
            .npc           (bank_npc[b]),
            .pre           (bank_pre[b]),
            .plv           (bank_plv[b]),
            .excp_arg      (bank_excp_arg[b]),
            .head_ir       (bank_head_ir[b]),
            .head_pc       (bank_head_pc[b]),
            .head_npc      (bank_head_npc[b]),
            .head_pre      (bank_head_pre[b]),
            .head_plv      (bank_head_plv[b]),
            .head_excp_arg (bank_head_excp_arg[b]),
            .empty         (bank_empty[b]),
            .count         (bank_count[b])
        );
    end

    issue_merger i_merger
    (
        .clk                (clk),
        .rstn               (rstn),
        .stall              (stall),
        .flush              (flush),
        .if0                (if0),
        .if1                (if1),
        .bank_head_ir       (bank_head_ir),
        .bank_head_pc       (bank_head_pc),
        .bank_head_npc      (bank_head_npc),
        .bank_head_pre      (bank_head_pre),
        .bank_head_plv      (bank_head_plv),
        .bank_head_excp_arg (bank_head_excp_arg),
        .bank_empty         (bank_empty),
        .bank_pop           (bank_pop),
        .ir0                (ir0),
        .ir1                (ir1),
        .pc0                (pc0),
        .pc1                (pc1),
        .npc0               (npc0),
        .npc1               (npc1),
        .pre0               (pre0),
        .pre1               (pre1),
        .plv0               (plv0),
        .plv1               (plv1),
        .excp_arg0          (excp_arg0),
        .excp_arg1          (excp_arg1),
        .valid0             (valid0),
        .valid1             (valid1)
    );

endmodule

// File: issue_merger.sv
`timescale 1ns/1ps

module issue_merger import fb_pkg::*;
(
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              stall,
    input  logic                              flush,
    input  logic                              if0,
    input  logic                              if1,
    input  logic [NUM_BANKS-1:0][XLEN-1:0]    bank_head_ir,
    input  logic [NUM_BANKS-1:0][XLEN-1:0]    bank_head_pc,
    input  logic [NUM_BANKS-1:0][XLEN-1:0]    bank_head_npc,
    input  logic [NUM_BANKS-1:0][PRE_W-1:0]   bank_head_pre,
    input  logic [NUM_BANKS-1:0][PLV_W-1:0]   bank_head_plv,
    input  logic [NUM_BANKS-1:0][EXCP_W-1:0]  bank_head_excp_arg,
    input  logic [NUM_BANKS-1:0]              bank_empty,
    output logic [NUM_BANKS-1:0]              bank_pop,
    output logic [XLEN-1:0]                   ir0,
    output logic [XLEN-1:0]                   ir1,
    output logic [XLEN-1:0]                   pc0,
    output logic [XLEN-1:0]                   pc1,
    output logic [XLEN-1:0]                   npc0,
    output logic [XLEN-1:0]                   npc1,
    output logic [PRE_W-1:0]                  pre0,
    output logic [PRE_W-1:0]                  pre1,
    output logic [PLV_W-1:0]                  plv0,
    output logic [PLV_W-1:0]                  plv1,
    output logic [EXCP_W-1:0]                 excp_arg0,
    output logic [EXCP_W-1:0]                 excp_arg1,
    output logic                              valid0,
    output logic                              valid1
);

    logic rd_sel;                             // Bank holding the oldest entry
    logic other_sel;
    logic take0;
    logic take1;

    assign other_sel = ~rd_sel;

    // ------------------------------------------------------------
    // Slot selection
    // ------------------------------------------------------------

    assign valid0 = ~bank_empty[rd_sel];
    assign valid1 = valid0 & ~bank_empty[other_sel];

    assign ir0       = bank_head_ir[rd_sel];
    assign ir1       = bank_head_ir[other_sel];
    assign pc0       = bank_head_pc[rd_sel];
    assign pc1       = bank_head_pc[other_sel];
    assign npc0      = bank_head_npc[rd_sel];
    assign npc1      = bank_head_npc[other_sel];
    assign pre0      = bank_head_pre[rd_sel];
    assign pre1      = bank_head_pre[other_sel];
    assign plv0      = bank_head_plv[rd_sel];
    assign plv1      = bank_head_plv[other_sel];
    assign excp_arg0 = bank_head_excp_arg[rd_sel];
    assign excp_arg1 = bank_head_excp_arg[other_sel];

    // ------------------------------------------------------------
    // Takes and pops
    // ------------------------------------------------------------

    assign take0 = valid0 & if0 & ~stall & ~flush;
    assign take1 = take0 & valid1 & if1;

    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
            bank_pop[b] = (1'(b) == rd_sel) ? take0 : take1;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            rd_sel <= 1'b0;
        else if (flush)
            rd_sel <= 1'b0;
        else if (take0 && !take1)
            rd_sel <= other_sel;              // Oldest moves to other bank
    end

endmodule

// File: fetch_bank.sv
`timescale 1ns/1ps

module fetch_bank import fb_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   flush,
    input  logic                   stall,
    input  logic                   push,
    input  logic                   pop,
    input  logic [XLEN-1:0]        ir,
    input  logic [XLEN-1:0]        pc,
    input  logic [XLEN-1:0]        npc,
    input  logic [PRE_W-1:0]       pre,
    input  logic [PLV_W-1:0]       plv,
    input  logic [EXCP_W-1:0]      excp_arg,
    output logic [XLEN-1:0]        head_ir,
    output logic [XLEN-1:0]        head_pc,
    output logic [XLEN-1:0]        head_npc,
    output logic [PRE_W-1:0]       head_pre,
    output logic [PLV_W-1:0]       head_plv,
    output logic [EXCP_W-1:0]      head_excp_arg,
    output logic                   empty,
    output logic [BANK_CNT_W-1:0]  count
);

    logic [XLEN-1:0]   mem_ir   [BANK_DEPTH];
    logic [XLEN-1:0]   mem_pc   [BANK_DEPTH];
    logic [XLEN-1:0]   mem_npc  [BANK_DEPTH];
    logic [PRE_W-1:0]  mem_pre  [BANK_DEPTH];
    logic [PLV_W-1:0]  mem_plv  [BANK_DEPTH];
    logic [EXCP_W-1:0] mem_excp [BANK_DEPTH];

    logic [BANK_PTR_W-1:0] wr_ptr;
    logic [BANK_PTR_W-1:0] rd_ptr;
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push & ~stall & ~flush;
    assign do_pop  = pop & ~stall & ~flush;

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem_ir[wr_ptr]   <= ir;
            mem_pc[wr_ptr]   <= pc;
            mem_npc[wr_ptr]  <= npc;
            mem_pre[wr_ptr]  <= pre;
            mem_plv[wr_ptr]  <= plv;
            mem_excp[wr_ptr] <= excp_arg;
        end
    end

    // Pointers wrap at BANK_DEPTH by their width
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else if (flush)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + BANK_PTR_W'(1);
            if (do_pop)
                rd_ptr <= rd_ptr + BANK_PTR_W'(1);
            if (do_push && !do_pop)
                count <= count + BANK_CNT_W'(1);
            else if (do_pop && !do_push)
                count <= count - BANK_CNT_W'(1);
        end
    end

    assign head_ir       = mem_ir[rd_ptr];
    assign head_pc       = mem_pc[rd_ptr];
    assign head_npc      = mem_npc[rd_ptr];
    assign head_pre      = mem_pre[rd_ptr];
    assign head_plv      = mem_plv[rd_ptr];
    assign head_excp_arg = mem_excp[rd_ptr];
    assign empty         = (count == '0);

endmodule

// File: fetch_packet_splitter.sv
`timescale 1ns/1ps

module fetch_packet_splitter import fb_pkg::*;
(
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  stall,
    input  logic                                  flush,
    input  logic                                  icache_valid,
    input  logic                                  flag,
    input  logic [XLEN-1:0]                       pc,
    input  logic [XLEN-1:0]                       npc,
    input  logic [FETCH_W-1:0]                    irin,
    input  logic [PRE_W-1:0]                      pre,
    input  logic [PLV_W-1:0]                      plv,
    input  logic [EXCP_W-1:0]                     excp_arg,
    input  logic [NUM_BANKS-1:0][BANK_CNT_W-1:0]  bank_count,
    output logic [NUM_BANKS-1:0]                  bank_push,
    output logic [NUM_BANKS-1:0][XLEN-1:0]        bank_ir,
    output logic [NUM_BANKS-1:0][XLEN-1:0]        bank_pc,
    output logic [NUM_BANKS-1:0][XLEN-1:0]        bank_npc,
    output logic [NUM_BANKS-1:0][PRE_W-1:0]       bank_pre,
    output logic [NUM_BANKS-1:0][PLV_W-1:0]       bank_plv,
    output logic [NUM_BANKS-1:0][EXCP_W-1:0]      bank_excp_arg,
    output logic                                  stall_fetch_buffer
);

    logic wr_sel;                             // Bank for next older insn
    logic accept;

    assign accept = icache_valid & ~stall & ~flush;

    // ------------------------------------------------------------
    // Fan-out of one delivery over the banks
    // ------------------------------------------------------------

    always_comb
    begin
        for (int b = 0; b < NUM_BANKS; b++)
        begin
            if (1'(b) == wr_sel)
            begin
                bank_push[b]     = accept;    // Older, lower half
                bank_ir[b]       = irin[XLEN-1:0];
                bank_pc[b]       = pc;
                bank_excp_arg[b] = excp_arg;
            end
            else
            begin
                bank_push[b]     = accept & flag;
                bank_ir[b]       = irin[FETCH_W-1:XLEN];
                bank_pc[b]       = pc + XLEN'(INSN_BYTES);
                bank_excp_arg[b] = '0;
            end
            bank_npc[b] = npc;
            bank_pre[b] = pre;
            bank_plv[b] = plv;
        end
    end

    always_comb
    begin
        stall_fetch_buffer = 1'b0;
        for (int b = 0; b < NUM_BANKS; b++)
            stall_fetch_buffer |= (bank_count[b] == BANK_CNT_W'(BANK_DEPTH));
    end

    // A pair fills both banks, so the selection only moves on a single
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            wr_sel <= 1'b0;
        else if (flush)
            wr_sel <= 1'b0;
        else if (accept && !flag)
            wr_sel <= ~wr_sel;
    end

endmodule

// File: fb_pkg.sv
package fb_pkg;

    // ------------------------------------------------------------
    // Instruction and side-band widths
    // ------------------------------------------------------------

    localparam int XLEN   = 32;               // Instruction and pc width
    localparam int PRE_W  = 64;               // Branch prediction word
    localparam int PLV_W  = 2;                // Privilege level
    localparam int EXCP_W = 16;               // Exception argument

    // ------------------------------------------------------------
    // Bank organisation
    // ------------------------------------------------------------

    // Instructions alternate between the banks in program order,
    // so the oldest entry is always at the head of one of them
    localparam int NUM_BANKS  = 2;
    localparam int BANK_DEPTH = 8;            // 16 entries in total

    localparam int BANK_PTR_W = 3;            // Indexes BANK_DEPTH entries
    localparam int BANK_CNT_W = 4;            // Holds 0 to BANK_DEPTH

    // ------------------------------------------------------------
    // Derived values
    // ------------------------------------------------------------

    localparam int FETCH_W = 2 * XLEN;        // Two instructions per delivery
    localparam int INSN_BYTES = 4;            // Step to the second pc

endpackage
